// File: heap_config.svh
/*
  Heap geometry. Array count and array length are powers of two
  taken from these widths. All RTL sees them through heapPkg.
*/
`ifndef HEAP_CONFIG_SVH
`define HEAP_CONFIG_SVH

// ----------------------------------------------
// Geometry
// ----------------------------------------------
`define HEAP_ARRAY_BITS 2   // 4 arrays
`define HEAP_INDEX_BITS 3   // 8 elements per array

// ----------------------------------------------
// Payload
// ----------------------------------------------
`define HEAP_DATA_BITS 12   // Element width

`endif

// File: heapPkg.sv
/*
  Widths and enumerations shared by the heap RTL and its testbench.
  Encodings of actionT and errorT are fixed by declaration order.
*/
`include "heap_config.svh"

package heapPkg;

  // ----------------------------------------------
  // Geometry
  // ----------------------------------------------
  localparam int arrayCount  = 1 << `HEAP_ARRAY_BITS;  // Arrays in the heap
  localparam int arrayLength = 1 << `HEAP_INDEX_BITS;  // Elements per array

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayIdT;       // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] indexT;         // Element index
  typedef logic [`HEAP_INDEX_BITS:0]   sizeT;          // Size, holds full length
  typedef logic [`HEAP_DATA_BITS-1:0]  dataT;          // Element value

  // ----------------------------------------------
  // Commands and errors
  // ----------------------------------------------
  typedef enum logic [3:0] {
    actClear,                                          // Release every array
    actWrite,                                          // Write, may extend size
    actRead,                                           // Read inside size
    actSize,                                           // Return size
    actInc,                                            // Size plus one
    actDec,                                            // Size minus one
    actPush,                                           // Append element
    actPop,                                            // Remove last element
    actAlloc,                                          // Get an array
    actFree                                            // Return an array
  } actionT;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                                   // Never handed out
    errFreed,                                          // Handed out, then freed
    errOutOfBounds,                                    // Read at or past size
    errEmpty,                                          // Pop or Dec at size 0
    errFull,                                           // Push or Inc at full length
    errOutOfMemory                                     // No array left
  } errorT;

  typedef enum logic [1:0] {
    stIdle,                                            // Waiting for start
    stCheck,                                           // Validate, issue read
    stCommit                                           // Apply, form result
  } stateT;

endpackage

// File: heapRam.sv
/*
  Single-port-write, synchronous-read RAM without reset.
  A read of the address being written returns the old word.
*/
`include "heap_config.svh"

module heapRam #(
  parameter type payloadT = heapPkg::dataT,                      // Stored word
  parameter int  depth    = 1 << (`HEAP_ARRAY_BITS + `HEAP_INDEX_BITS)
) (
  input  logic                     clock,
  input  logic                     write,                        // Write strobe
  input  logic [$clog2(depth)-1:0] writeAddr,
  input  payloadT                  writeData,
  input  logic [$clog2(depth)-1:0] readAddr,
  output payloadT                  readData                      // One cycle after readAddr
);

  payloadT mem [depth];                                          // Storage

  always_ff @(posedge clock) begin
    if (write) begin
      mem[writeAddr] <= writeData;
    end
    readData <= mem[readAddr];                                   // Registered read
  end

endmodule

// File: heapControl.sv
/*
  Three-state command FSM, one command in flight. start is ignored
  while busy. Writes and strobes are issued in stCommit only and only
  when the check found no error. done pulses one cycle, two edges on.
*/
module heapControl (
  input  logic                clock,
  input  logic                resetN,
  input  logic                start,
  input  heapPkg::actionT     action,
  input  heapPkg::arrayIdT    array,
  input  heapPkg::indexT      index,
  input  heapPkg::dataT       data,
  output heapPkg::dataT       result,
  output heapPkg::errorT      error,
  output logic                done,
  output logic                busy,
  output logic                allocate,                          // Allocator strobes
  output logic                releaseArray,
  output logic                clearAll,
  output heapPkg::arrayIdT    releaseId,
  input  logic                allocated,
  input  logic                freed,                             // Below high-water, flag clear
  input  logic                canAllocate,
  input  heapPkg::arrayIdT    nextId,
  output heapPkg::arrayIdT    sizeArray,                         // Size table port
  output logic                sizeWrite,
  output heapPkg::sizeT       sizeValue,
  output logic                sizeInc,
  output logic                sizeDec,
  input  heapPkg::sizeT       size,
  output logic [$bits(heapPkg::arrayIdT)+$bits(heapPkg::indexT)-1:0] ramReadAddr,
  output logic [$bits(heapPkg::arrayIdT)+$bits(heapPkg::indexT)-1:0] ramWriteAddr,
  output logic                ramWrite,
  output heapPkg::dataT       ramWriteData,
  input  heapPkg::dataT       ramReadData
);

  heapPkg::stateT   state;
  heapPkg::actionT  actReg;                                      // Sampled command
  heapPkg::arrayIdT arrayReg;
  heapPkg::indexT   indexReg;
  heapPkg::dataT    dataReg;
  heapPkg::errorT   checkResult;                                 // Found in stCheck
  heapPkg::errorT   checkReg;                                    // Held for stCommit
  heapPkg::dataT    commitResult;
  logic             commitOk;

  // ----------------------------------------------
  // Sequencing
  // ----------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state  <= heapPkg::stIdle;
      done   <= 1'b0;
      result <= '0;
      error  <= heapPkg::errNone;
    end else begin
      done <= 1'b0;
      case (state)
        heapPkg::stIdle:  if (start && !done) state <= heapPkg::stCheck;
        heapPkg::stCheck: state <= heapPkg::stCommit;
        default: begin                                           // stCommit
          state  <= heapPkg::stIdle;
          done   <= 1'b1;
          result <= commitResult;
          error  <= checkReg;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == heapPkg::stIdle && start && !done) begin        // Capture command
      actReg   <= action;
      arrayReg <= array;
      indexReg <= index;
      dataReg  <= data;
    end
    if (state == heapPkg::stCheck) checkReg <= checkResult;
  end

  assign busy = (state != heapPkg::stIdle) || done;              // Until done falls

  // ----------------------------------------------
  // Checks
  // ----------------------------------------------
  always_comb begin
    checkResult = heapPkg::errNone;
    if (actReg != heapPkg::actClear && actReg != heapPkg::actAlloc) begin
      if (freed) checkResult = heapPkg::errFreed;
      else if (!allocated) checkResult = heapPkg::errNotAllocated;
    end
    if (checkResult == heapPkg::errNone) begin
      case (actReg)
        heapPkg::actRead:
          if ({1'b0, indexReg} >= size) checkResult = heapPkg::errOutOfBounds;
        heapPkg::actPop, heapPkg::actDec:
          if (size == '0) checkResult = heapPkg::errEmpty;
        heapPkg::actPush, heapPkg::actInc:
          if (size == heapPkg::sizeT'(heapPkg::arrayLength)) checkResult = heapPkg::errFull;
        heapPkg::actAlloc:
          if (!canAllocate) checkResult = heapPkg::errOutOfMemory;
        default: ;
      endcase
    end
  end

  // ----------------------------------------------
  // Commit strobes and data
  // ----------------------------------------------
  assign commitOk = (state == heapPkg::stCommit) && (checkReg == heapPkg::errNone);

  assign allocate     = commitOk && actReg == heapPkg::actAlloc;
  assign releaseArray = commitOk && actReg == heapPkg::actFree;
  assign clearAll     = commitOk && actReg == heapPkg::actClear;
  assign releaseId    = arrayReg;

  // New array gets its size reset, all else works on the command's array
  assign sizeArray = (actReg == heapPkg::actAlloc) ? nextId : arrayReg;
  assign sizeWrite = commitOk && (actReg == heapPkg::actAlloc ||
                     (actReg == heapPkg::actWrite && {1'b0, indexReg} >= size));
  assign sizeValue = (actReg == heapPkg::actAlloc) ? '0 : {1'b0, indexReg} + 1'b1;
  assign sizeInc   = commitOk && (actReg == heapPkg::actInc || actReg == heapPkg::actPush);
  assign sizeDec   = commitOk && (actReg == heapPkg::actDec || actReg == heapPkg::actPop);

  assign ramReadAddr  = {arrayReg, (actReg == heapPkg::actPop) ?
                         heapPkg::indexT'(size - 1'b1) : indexReg};  // Pop reads the top
  assign ramWrite     = commitOk && (actReg == heapPkg::actWrite || actReg == heapPkg::actPush);
  assign ramWriteAddr = {arrayReg, (actReg == heapPkg::actPush) ?
                         heapPkg::indexT'(size) : indexReg};
  assign ramWriteData = dataReg;

  always_comb begin
    commitResult = '0;                                           // Errors give zero
    if (checkReg == heapPkg::errNone) begin
      case (actReg)
        heapPkg::actWrite:                 commitResult = dataReg;
        heapPkg::actRead, heapPkg::actPop: commitResult = ramReadData;
        heapPkg::actSize:                  commitResult = heapPkg::dataT'(size);
        heapPkg::actAlloc:                 commitResult = heapPkg::dataT'(nextId);
        default:                           commitResult = '0;
      endcase
    end
  end

  // One result per command, never back to back
  assert property (@(posedge clock) disable iff (!resetN) done |=> !done);
  // Pushes land below the full length
  assert property (@(posedge clock) disable iff (!resetN)
                   ramWrite && actReg == heapPkg::actPush |->
                   size < heapPkg::sizeT'(heapPkg::arrayLength));

endmodule

// File: arrayAllocator.sv
/*
  Hands out array numbers. Freed numbers are reused LIFO before the
  high-water mark grows. Every array may be allocated. Clear drops both
  counters; stale flags above the high-water mark are never looked at.
*/
module arrayAllocator (
  input  logic             clock,
  input  logic             resetN,
  input  logic             allocate,                             // Take nextId
  input  logic             releaseArray,                         // Give back releaseId
  input  logic             clearAll,
  input  heapPkg::arrayIdT array,                                // Command's array
  input  heapPkg::arrayIdT releaseId,
  output logic             allocated,
  output logic             freed,
  output logic             canAllocate,
  output heapPkg::arrayIdT nextId
);

  logic [$bits(heapPkg::arrayIdT):0] highWater;                  // Arrays ever handed out
  logic [$bits(heapPkg::arrayIdT):0] top;                        // Freed stack depth
  logic [heapPkg::arrayCount-1:0]    flags;                      // Currently allocated
  heapPkg::arrayIdT                  stackTopId;                 // Entry at top minus one
  logic                              belowMark;

  // ----------------------------------------------
  // Freed-array stack
  // ----------------------------------------------
  heapRam #(
    .payloadT (heapPkg::arrayIdT),
    .depth    (heapPkg::arrayCount)
  ) freedStack (
    .clock     (clock),
    .write     (releaseArray),
    .writeAddr (heapPkg::arrayIdT'(top)),                        // Push at top
    .writeData (releaseId),
    .readAddr  (heapPkg::arrayIdT'(top - 1'b1)),                 // Always the top entry
    .readData  (stackTopId)
  );

  // ----------------------------------------------
  // Status
  // ----------------------------------------------
  assign belowMark   = {1'b0, array} < highWater;
  assign allocated   = belowMark && flags[array];
  assign freed       = belowMark && !flags[array];
  assign canAllocate = (top != '0) || (highWater < heapPkg::arrayCount);
  assign nextId      = (top != '0) ? stackTopId : heapPkg::arrayIdT'(highWater);

  // ----------------------------------------------
  // Counters and flags
  // ----------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      highWater <= '0;
      top       <= '0;
      flags     <= '0;
    end else if (clearAll) begin
      highWater <= '0;                                           // Flags left stale
      top       <= '0;
    end else if (allocate) begin
      flags[nextId] <= 1'b1;
      if (top != '0) top <= top - 1'b1;                          // Reuse freed first
      else highWater <= highWater + 1'b1;
    end else if (releaseArray) begin
      flags[releaseId] <= 1'b0;
      top              <= top + 1'b1;
    end
  end

  // Controller must check for space before taking an array
  assert property (@(posedge clock) disable iff (!resetN) allocate |-> canAllocate);
  // Double frees are caught upstream, so the stack cannot overflow
  assert property (@(posedge clock) disable iff (!resetN) top <= heapPkg::arrayCount);

endmodule

// File: sizeTable.sv
/*
  One size register per array, read combinationally.
  Set, increment and decrement apply to sizeArray only.
  No range check here; the controller screens Inc and Dec.
*/
module sizeTable (
  input  logic             clock,
  input  logic             resetN,
  input  logic             clearAll,                             // Zero every size
  input  heapPkg::arrayIdT sizeArray,
  input  logic             sizeWrite,
  input  heapPkg::sizeT    sizeValue,
  input  logic             sizeInc,
  input  logic             sizeDec,
  output heapPkg::sizeT    size
);

  heapPkg::sizeT sizes [heapPkg::arrayCount];

  assign size = sizes[sizeArray];                                // Selected array

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < heapPkg::arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else if (clearAll) begin
      for (int i = 0; i < heapPkg::arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else if (sizeWrite) begin
      sizes[sizeArray] <= sizeValue;
    end else if (sizeInc) begin
      sizes[sizeArray] <= sizes[sizeArray] + 1'b1;
    end else if (sizeDec) begin
      sizes[sizeArray] <= sizes[sizeArray] - 1'b1;
    end
  end

  // Each command drives at most one kind of size update
  assert property (@(posedge clock) disable iff (!resetN)
                   $onehot0({clearAll, sizeWrite, sizeInc, sizeDec}));

endmodule

// File: heapMemory.sv
/*
  Heap of fixed-size arrays. One command per start strobe; result and
  error are valid while done is high. No back-pressure.
*/
module heapMemory (
  input  logic             clock,
  input  logic             resetN,
  input  logic             start,
  input  heapPkg::actionT  action,
  input  heapPkg::arrayIdT array,
  input  heapPkg::indexT   index,
  input  heapPkg::dataT    data,
  output heapPkg::dataT    result,
  output heapPkg::errorT   error,
  output logic             done,
  output logic             busy
);

  logic                    allocate, releaseArray, clearAll;
  logic                    allocated, freed, canAllocate;
  heapPkg::arrayIdT        releaseId, nextId, sizeArray;
  logic                    sizeWrite, sizeInc, sizeDec;
  heapPkg::sizeT           sizeValue, size;
  logic [$bits(heapPkg::arrayIdT)+$bits(heapPkg::indexT)-1:0] ramReadAddr, ramWriteAddr;
  logic                    ramWrite;
  heapPkg::dataT           ramWriteData, ramReadData;

  heapControl control (
    .clock        (clock),        .resetN       (resetN),
    .start        (start),        .action       (action),
    .array        (array),        .index        (index),
    .data         (data),         .result       (result),
    .error        (error),        .done         (done),
    .busy         (busy),         .allocate     (allocate),
    .releaseArray (releaseArray), .clearAll     (clearAll),
    .releaseId    (releaseId),    .allocated    (allocated),
    .freed        (freed),        .canAllocate  (canAllocate),
    .nextId       (nextId),       .sizeArray    (sizeArray),
    .sizeWrite    (sizeWrite),    .sizeValue    (sizeValue),
    .sizeInc      (sizeInc),      .sizeDec      (sizeDec),
    .size         (size),         .ramReadAddr  (ramReadAddr),
    .ramWriteAddr (ramWriteAddr), .ramWrite     (ramWrite),
    .ramWriteData (ramWriteData), .ramReadData  (ramReadData)
  );

  // releaseId carries the registered command's array
  arrayAllocator allocator (
    .clock        (clock),        .resetN       (resetN),
    .allocate     (allocate),     .releaseArray (releaseArray),
    .clearAll     (clearAll),     .array        (releaseId),
    .releaseId    (releaseId),    .allocated    (allocated),
    .freed        (freed),        .canAllocate  (canAllocate),
    .nextId       (nextId)
  );

  sizeTable sizes (
    .clock     (clock),     .resetN    (resetN),
    .clearAll  (clearAll),  .sizeArray (sizeArray),
    .sizeWrite (sizeWrite), .sizeValue (sizeValue),
    .sizeInc   (sizeInc),   .sizeDec   (sizeDec),
    .size      (size)
  );

  heapRam #(
    .payloadT (heapPkg::dataT),
    .depth    (heapPkg::arrayCount * heapPkg::arrayLength)   // Arrays in fixed blocks
  ) elements (
    .clock     (clock),
    .write     (ramWrite),
    .writeAddr (ramWriteAddr),
    .writeData (ramWriteData),
    .readAddr  (ramReadAddr),
    .readData  (ramReadData)
  );

endmodule

// File: heapMemoryTb.sv
/*
  Directed testbench for heapMemory. runOp changes the operands once start
  has dropped, so the DUT must work from its sampled copy. Stops at first mismatch.
*/
module heapMemoryTb;

  localparam int period      = 10;
  localparam int resetCycles = 10;
  localparam int opCount     = 60;                               // Commands issued, with margin
  localparam int doneLimit   = 8;                                // Cycles allowed for done

  logic             clock;
  logic             resetN;
  logic             start;
  heapPkg::actionT  action;
  heapPkg::arrayIdT array;
  heapPkg::indexT   index;
  heapPkg::dataT    data;
  heapPkg::dataT    result;
  heapPkg::errorT   error;
  logic             done;
  logic             busy;

  heapPkg::dataT    opResult;                                    // Captured while done
  heapPkg::errorT   opError;
  int               seed = 21;

  heapMemory heapMemory_inst (
    .clock  (clock),  .resetN (resetN),
    .start  (start),  .action (action),
    .array  (array),  .index  (index),
    .data   (data),   .result (result),
    .error  (error),  .done   (done),
    .busy   (busy)
  );

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  initial begin                                                  // Watchdog
    #((opCount * 6 + resetCycles) * period);
    $display("Timeout: the tests did not finish in the expected time");
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic checkData(input string name, input heapPkg::dataT expected,
                           input heapPkg::dataT actual);
    if (actual !== expected) begin
      $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic checkError(input string name, input heapPkg::errorT expected,
                            input heapPkg::errorT actual);
    if (actual !== expected) begin
      $display("ERR t=%0t %s expected=%s actual=%s(%0d)", $time, name,
               expected.name(), actual.name(), actual);
      $display("TEST FAILED");
      $fatal(1, "Error code mismatch");
    end
  endtask

  task automatic checkSize(input string name, input heapPkg::sizeT expected,
                           input heapPkg::sizeT actual);
    if (actual !== expected) begin
      $display("ERR t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "Size mismatch");
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERR t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "Control mismatch");
    end
  endtask

  // --------------------------------------------------
  // Command driver
  // --------------------------------------------------
  // Called 1 unit after an edge, returns 1 unit after the edge where done falls
  task automatic runOp(input heapPkg::actionT act, input heapPkg::arrayIdT id,
                       input heapPkg::indexT idx, input heapPkg::dataT value);
    int waited;
    action = act;
    array  = id;
    index  = idx;
    data   = value;
    start  = 1'b1;
    @(posedge clock);
    #1;
    start  = 1'b0;
    array  = ~id;                                                // Operands no longer valid
    index  = ~idx;
    data   = ~value;
    waited = 0;
    while (!done && waited < doneLimit) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (!done) begin
      $display("No done pulse within %0d cycles of start, action %s", doneLimit, act.name());
      $display("TEST FAILED");
      $fatal(1, "Missing done");
    end
    opResult = result;
    opError  = error;
    @(posedge clock);                                            // Let done fall
    #1;
  endtask

  task automatic sizeOf(input heapPkg::arrayIdT id, input heapPkg::sizeT expected);
    runOp(heapPkg::actSize, id, '0, '0);
    checkError("error", heapPkg::errNone, opError);
    checkSize("size", expected, heapPkg::sizeT'(opResult));
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic clearAndAlloc;
    runOp(heapPkg::actClear, '0, '0, '0);
    checkError("error", heapPkg::errNone, opError);
    for (int i = 0; i < 2; i++) begin
      runOp(heapPkg::actAlloc, '0, '0, '0);
      checkError("error", heapPkg::errNone, opError);
      checkData("result", heapPkg::dataT'(i), opResult);         // Ids from the high-water mark
      sizeOf(heapPkg::arrayIdT'(i), '0);
    end
  endtask

  task automatic writeReadSize;
    heapPkg::dataT first;
    heapPkg::dataT second;
    first  = heapPkg::dataT'($random(seed));
    second = heapPkg::dataT'($random(seed));
    runOp(heapPkg::actWrite, 2'd0, 3'd3, first);
    checkError("error", heapPkg::errNone, opError);
    checkData("result", first, opResult);
    sizeOf(2'd0, 4);                                             // Write past end extends
    runOp(heapPkg::actRead, 2'd0, 3'd3, '0);
    checkError("error", heapPkg::errNone, opError);
    checkData("result", first, opResult);
    runOp(heapPkg::actRead, 2'd0, 3'd5, '0);
    checkError("error", heapPkg::errOutOfBounds, opError);
    runOp(heapPkg::actWrite, 2'd0, 3'd7, second);
    checkError("error", heapPkg::errNone, opError);
    sizeOf(2'd0, 8);
  endtask

  task automatic pushPop;
    heapPkg::dataT pushed [heapPkg::arrayLength];
    for (int i = 0; i < heapPkg::arrayLength; i++) begin
      pushed[i] = heapPkg::dataT'($random(seed));
      runOp(heapPkg::actPush, 2'd1, '0, pushed[i]);
      checkError("error", heapPkg::errNone, opError);
    end
    sizeOf(2'd1, heapPkg::sizeT'(heapPkg::arrayLength));
    runOp(heapPkg::actPush, 2'd1, '0, heapPkg::dataT'($random(seed)));
    checkError("error", heapPkg::errFull, opError);
    for (int i = heapPkg::arrayLength - 1; i >= 0; i--) begin    // LIFO order
      runOp(heapPkg::actPop, 2'd1, '0, '0);
      checkError("error", heapPkg::errNone, opError);
      checkData("result", pushed[i], opResult);
    end
    runOp(heapPkg::actPop, 2'd1, '0, '0);
    checkError("error", heapPkg::errEmpty, opError);
    runOp(heapPkg::actInc, 2'd1, '0, '0);
    checkError("error", heapPkg::errNone, opError);
    sizeOf(2'd1, 1);
    runOp(heapPkg::actDec, 2'd1, '0, '0);
    checkError("error", heapPkg::errNone, opError);
    sizeOf(2'd1, 0);
  endtask

  task automatic freeAndReuse;
    runOp(heapPkg::actFree, 2'd1, '0, '0);
    checkError("error", heapPkg::errNone, opError);
    runOp(heapPkg::actFree, 2'd0, '0, '0);
    checkError("error", heapPkg::errNone, opError);
    runOp(heapPkg::actRead, 2'd0, 3'd3, '0);
    checkError("error", heapPkg::errFreed, opError);
    runOp(heapPkg::actFree, 2'd0, '0, '0);                       // Double free
    checkError("error", heapPkg::errFreed, opError);
    runOp(heapPkg::actRead, 2'd3, '0, '0);                       // Never handed out
    checkError("error", heapPkg::errNotAllocated, opError);
    runOp(heapPkg::actAlloc, '0, '0, '0);
    checkError("error", heapPkg::errNone, opError);
    checkData("result", 0, opResult);                            // Last freed comes back first
    runOp(heapPkg::actAlloc, '0, '0, '0);
    checkError("error", heapPkg::errNone, opError);
    checkData("result", 1, opResult);
    sizeOf(2'd0, 0);                                             // Reused array starts empty
  endtask

  task automatic exhaustion;
    runOp(heapPkg::actClear, '0, '0, '0);
    checkError("error", heapPkg::errNone, opError);
    for (int i = 0; i < heapPkg::arrayCount; i++) begin
      runOp(heapPkg::actAlloc, '0, '0, '0);
      checkError("error", heapPkg::errNone, opError);
      checkData("result", heapPkg::dataT'(i), opResult);
    end
    runOp(heapPkg::actAlloc, '0, '0, '0);
    checkError("error", heapPkg::errOutOfMemory, opError);
    runOp(heapPkg::actClear, '0, '0, '0);
    checkError("error", heapPkg::errNone, opError);
    runOp(heapPkg::actAlloc, '0, '0, '0);
    checkError("error", heapPkg::errNone, opError);
    checkData("result", 0, opResult);
  endtask

  task automatic checkTiming;
    action = heapPkg::actSize;
    array  = '0;
    index  = '0;
    data   = '0;
    start  = 1'b1;
    @(posedge clock);                                            // Edge that samples start
    #1;
    checkBit("done", 1'b0, done);
    checkBit("busy", 1'b1, busy);
    action = heapPkg::actAlloc;                                  // Stray start while busy
    @(posedge clock);
    #1;
    checkBit("done", 1'b0, done);
    checkBit("busy", 1'b1, busy);
    @(posedge clock);                                            // Second edge after sampling
    #1;
    checkBit("done", 1'b1, done);
    checkBit("busy", 1'b1, busy);
    checkError("error", heapPkg::errNone, error);
    checkSize("size", 0, heapPkg::sizeT'(result));
    @(posedge clock);                                            // Stray start seen with done high
    #1;
    start = 1'b0;
    checkBit("done", 1'b0, done);
    checkBit("busy", 1'b0, busy);
    repeat (4) begin
      @(posedge clock);
      #1;
      checkBit("done", 1'b0, done);
    end
    runOp(heapPkg::actAlloc, '0, '0, '0);                        // Stray Alloc never ran
    checkError("error", heapPkg::errNone, opError);
    checkData("result", 1, opResult);
  endtask

  // --------------------------------------------------
  // Sequence
  // --------------------------------------------------
  initial begin
    resetN = 1'b0;
    start  = 1'b0;
    action = heapPkg::actClear;
    array  = '0;
    index  = '0;
    data   = '0;
    repeat (resetCycles) @(posedge clock);
    #1;
    resetN = 1'b1;
    checkBit("done", 1'b0, done);
    checkBit("busy", 1'b0, busy);
    checkError("error", heapPkg::errNone, error);
    checkData("result", '0, result);
    @(posedge clock);
    #1;
    clearAndAlloc();
    writeReadSize();
    pushPop();
    freeAndReuse();
    exhaustion();
    checkTiming();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: build.f
+incdir+.
heapPkg.sv
heapRam.sv
heapControl.sv
arrayAllocator.sv
sizeTable.sv
heapMemory.sv
heapMemoryTb.sv

// File: Makefile
# Verilator simulation of the heap testbench
VERILATOR ?= verilator
TOP       ?= heapMemoryTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
